/* Bender.yml */
package:
  name: rnn_ex_stage

sources:
  - hw/rnn_ex_wb_pkg.sv
  - hw/rnn_ex_arith_pkg.sv
  - hw/rnn_pipe_reg.sv
  - hw/rnn_spr_operand_file.sv
  - hw/rnn_ex_compute.sv
  - hw/rnn_wb_mux.sv
  - hw/rnn_ex_stage.sv
  - target: test
    files:
      - testbench/rnn_ex_stage_tb.sv

/* hw/rnn_ex_arith_pkg.sv */
// Arithmetic side types of the RNN execute stage: data word, op codes and request packet
package rnn_ex_arith_pkg;

  import rnn_ex_wb_pkg::*;

  ////////////////////////////////
  // Data path widths
  ////////////////////////////////

  localparam int XLEN        = 32;
  localparam int DOT8_LANES  = 4;  // 4 x 8 bit signed lanes per word
  localparam int DOT16_LANES = 2;  // 2 x 16 bit signed lanes per word

  typedef logic [XLEN-1:0] word_t;

  ////////////////////////////////
  // Operation codes
  ////////////////////////////////

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLT   = 4'd5,
    OP_SLTU  = 4'd6,
    OP_BEQ   = 4'd7,   // Branch compares
    OP_BNE   = 4'd8,
    OP_BLT   = 4'd9,
    OP_DOT8  = 4'd10,  // Dot products with accumulator
    OP_DOT16 = 4'd11
  } ex_op_e;

  // Request as issued from decode
  typedef struct packed {
    ex_op_e    op;
    word_t     operand_a;
    word_t     operand_b;
    word_t     operand_c;  // Accumulator for dot ops
    logic      use_spr;    // Take a/b from the special registers
    wspr_idx_t wspr_sel;
    aspr_idx_t aspr_sel;
    reg_addr_t rd;
    logic      rd_we;
  } ex_req_t;

endpackage

/* hw/rnn_ex_compute.sv */
// Combinational compute: scalar ALU, branch compare and signed dot products
`timescale 1ns/1ps

module rnn_ex_compute
  import rnn_ex_arith_pkg::*;
  import rnn_ex_wb_pkg::*;
(
  input  ex_req_t req_i,
  input  logic    valid_i,
  output ex_res_t res_o,
  output logic    res_valid_o
);

  logic lt_signed;
  logic lt_unsigned;
  logic equal;
  logic is_branch;

  logic signed [15:0]     dot8_prod  [DOT8_LANES];
  logic signed [31:0]     dot16_prod [DOT16_LANES];
  logic signed [XLEN-1:0] dot8_sum;
  logic signed [XLEN-1:0] dot16_sum;

  word_t res_data;
  logic  taken;

  // Shared comparator for SLT and branches
  assign lt_signed   = $signed(req_i.operand_a) < $signed(req_i.operand_b);
  assign lt_unsigned = req_i.operand_a < req_i.operand_b;
  assign equal       = req_i.operand_a == req_i.operand_b;

  assign is_branch = (req_i.op == OP_BEQ) || (req_i.op == OP_BNE) || (req_i.op == OP_BLT);

  //////////////////////////////
  // Dot product lanes
  //////////////////////////////

  always_comb begin
    dot8_sum = '0;
    for (int i = 0; i < DOT8_LANES; i++) begin
      dot8_prod[i] = $signed(req_i.operand_a[8*i +: 8]) * $signed(req_i.operand_b[8*i +: 8]);
      dot8_sum     = dot8_sum + dot8_prod[i];  // Sign extended to XLEN
    end
  end

  always_comb begin
    dot16_sum = '0;
    for (int i = 0; i < DOT16_LANES; i++) begin
      dot16_prod[i] = $signed(req_i.operand_a[16*i +: 16]) *
                      $signed(req_i.operand_b[16*i +: 16]);
      dot16_sum     = dot16_sum + dot16_prod[i];  // Wraps modulo 2^32
    end
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    res_data = '0;
    taken    = 1'b0;
    case (req_i.op)
      OP_ADD:   res_data = req_i.operand_a + req_i.operand_b;
      OP_SUB:   res_data = req_i.operand_a - req_i.operand_b;
      OP_AND:   res_data = req_i.operand_a & req_i.operand_b;
      OP_OR:    res_data = req_i.operand_a | req_i.operand_b;
      OP_XOR:   res_data = req_i.operand_a ^ req_i.operand_b;
      OP_SLT:   res_data = {{(XLEN-1){1'b0}}, lt_signed};
      OP_SLTU:  res_data = {{(XLEN-1){1'b0}}, lt_unsigned};
      OP_BEQ:   taken    = equal;  // Branches leave data at zero
      OP_BNE:   taken    = !equal;
      OP_BLT:   taken    = lt_signed;
      OP_DOT8:  res_data = dot8_sum + req_i.operand_c;
      OP_DOT16: res_data = dot16_sum + req_i.operand_c;
      default: ;
    endcase
  end

  assign res_o.wb.rd        = req_i.rd;
  assign res_o.wb.data      = res_data;
  assign res_o.branch_taken = taken;

  // Only results that write a register or decide a branch leave the stage
  assign res_valid_o = valid_i && (req_i.rd_we || is_branch);

endmodule

/* hw/rnn_ex_stage.sv */
// RNN execute stage top: operand select, compute and result register plus load port
`timescale 1ns/1ps

module rnn_ex_stage
  import rnn_ex_arith_pkg::*;
  import rnn_ex_wb_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,

  // Instruction issue
  input  logic      ex_valid_i,
  input  ex_req_t   ex_req_i,

  // Returned load data
  input  logic      load_valid_i,
  input  load_req_t load_i,

  // ALU write port
  output logic      alu_wb_valid_o,
  output wb_t       alu_wb_o,
  output logic      branch_taken_o,

  // Load write port
  output logic      load_wb_valid_o,
  output wb_t       load_wb_o
);

  ex_req_t resolved_req;  // Operands after SPR substitution
  logic    issue_valid;
  ex_req_t issue_req;
  ex_res_t comp_res;
  logic    comp_valid;
  ex_res_t res_q;

  //////////////////////////////
  // Operand select
  //////////////////////////////

  rnn_spr_operand_file u_spr_operand_file (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_valid_i (load_valid_i),
    .load_i       (load_i),
    .req_i        (ex_req_i),
    .req_o        (resolved_req)
  );

  rnn_pipe_reg #(
    .payload_t (ex_req_t)
  ) u_issue_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (ex_valid_i),
    .data_i  (resolved_req),
    .valid_o (issue_valid),
    .data_o  (issue_req)
  );

  //////////////////////////////
  // Compute and result
  //////////////////////////////

  rnn_ex_compute u_ex_compute (
    .req_i       (issue_req),
    .valid_i     (issue_valid),
    .res_o       (comp_res),
    .res_valid_o (comp_valid)
  );

  rnn_pipe_reg #(
    .payload_t (ex_res_t)
  ) u_result_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (comp_valid),
    .data_i  (comp_res),
    .valid_o (alu_wb_valid_o),
    .data_o  (res_q)
  );

  assign alu_wb_o       = res_q.wb;
  assign branch_taken_o = alu_wb_valid_o && res_q.branch_taken;  // Stale payload masked

  // Separate load port, never contends with the ALU port
  rnn_wb_mux u_wb_mux (
    .clk             (clk),
    .rst_n           (rst_n),
    .load_valid_i    (load_valid_i),
    .load_i          (load_i),
    .load_wb_valid_o (load_wb_valid_o),
    .load_wb_o       (load_wb_o)
  );

endmodule

/* hw/rnn_ex_wb_pkg.sv */
// Write-back side types of the RNN execute stage: register addresses, loads and results
package rnn_ex_wb_pkg;

  ////////////////////////////////
  // Register file addressing
  ////////////////////////////////

  localparam int REG_ADDR_W = 6;  // 32 GPRs plus FP/extension space
  localparam int N_WSPR     = 4;  // Weight special registers
  localparam int N_ASPR     = 2;  // Activation special registers

  typedef logic [REG_ADDR_W-1:0]     reg_addr_t;
  typedef logic [$clog2(N_WSPR)-1:0] wspr_idx_t;
  typedef logic [$clog2(N_ASPR)-1:0] aspr_idx_t;

  ////////////////////////////////
  // Load return path
  ////////////////////////////////

  // Where returned load data ends up
  typedef enum logic [1:0] {
    DST_GPR  = 2'd0,
    DST_WSPR = 2'd1,
    DST_ASPR = 2'd2
  } load_dst_e;

  typedef struct packed {
    logic [31:0] data;      // Raw load data
    load_dst_e   dst;
    reg_addr_t   rd;        // Only meaningful for DST_GPR
    wspr_idx_t   wspr_idx;  // Only meaningful for DST_WSPR
    aspr_idx_t   aspr_idx;  // Only meaningful for DST_ASPR
  } load_req_t;

  // One register file write
  typedef struct packed {
    reg_addr_t   rd;
    logic [31:0] data;
  } wb_t;

  // Compute result, ALU port write plus branch decision
  typedef struct packed {
    wb_t  wb;
    logic branch_taken;
  } ex_res_t;

endpackage

/* hw/rnn_pipe_reg.sv */
// Valid-tagged pipeline register, payload held while no new data arrives
`timescale 1ns/1ps

module rnn_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload only moves with a valid beat
  always_ff @(posedge clk) begin
    if (valid_i) begin
      data_o <= data_i;
    end
  end

endmodule

/* hw/rnn_spr_operand_file.sv */
// Weight and activation special registers, filled by loads, feeding dot operands
`timescale 1ns/1ps

module rnn_spr_operand_file
  import rnn_ex_arith_pkg::*;
  import rnn_ex_wb_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load_valid_i,
  input  load_req_t load_i,
  input  ex_req_t   req_i,
  output ex_req_t   req_o
);

  word_t [N_WSPR-1:0] wspr_q;  // Weights
  word_t [N_ASPR-1:0] aspr_q;  // Activations

  //////////////////////////////
  // Register update
  //////////////////////////////

  // Loaded word lands on the edge closing the load cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wspr_q <= '0;
      aspr_q <= '0;
    end else if (load_valid_i) begin
      case (load_i.dst)
        DST_WSPR: wspr_q[load_i.wspr_idx] <= load_i.data;
        DST_ASPR: aspr_q[load_i.aspr_idx] <= load_i.data;
        default: ;  // GPR loads handled on the load port
      endcase
    end
  end

  //////////////////////////////
  // Operand selection
  //////////////////////////////

  // Reads the stored value, so a same-cycle load is not yet visible
  always_comb begin
    req_o = req_i;
    if (req_i.use_spr) begin
      req_o.operand_a = aspr_q[req_i.aspr_sel];  // Activation on a
      req_o.operand_b = wspr_q[req_i.wspr_sel];  // Weight on b
    end
  end

endmodule

/* hw/rnn_wb_mux.sv */
// Load write port: routes returned GPR loads to a registered write-back
`timescale 1ns/1ps

module rnn_wb_mux
  import rnn_ex_wb_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load_valid_i,
  input  load_req_t load_i,
  output logic      load_wb_valid_o,
  output wb_t       load_wb_o
);

  logic gpr_load;
  wb_t  load_wb;

  //////////////////////////////
  // Destination decode
  //////////////////////////////

  // SPR-bound loads are consumed by the operand file
  always_comb begin
    gpr_load = 1'b0;
    if (load_valid_i) begin
      case (load_i.dst)
        DST_GPR:  gpr_load = 1'b1;
        DST_WSPR,
        DST_ASPR: gpr_load = 1'b0;
        default:  gpr_load = 1'b0;
      endcase
    end
  end

  assign load_wb.rd   = load_i.rd;
  assign load_wb.data = load_i.data;

  //////////////////////////////
  // Write port register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_wb_valid_o <= 1'b0;
    end else begin
      load_wb_valid_o <= gpr_load;  // One cycle pulse per GPR load
    end
  end

  always_ff @(posedge clk) begin
    if (gpr_load) begin
      load_wb_o <= load_wb;
    end
  end

endmodule

/* rnn_ex_stage.f */
hw/rnn_ex_wb_pkg.sv
hw/rnn_ex_arith_pkg.sv
hw/rnn_pipe_reg.sv
hw/rnn_spr_operand_file.sv
hw/rnn_ex_compute.sv
hw/rnn_wb_mux.sv
hw/rnn_ex_stage.sv
testbench/rnn_ex_stage_tb.sv

/* testbench/rnn_ex_stage_tb.sv */
// Table-driven testbench for the RNN execute stage with ALU, branch, dot and load cases
`timescale 1ns/1ps

module rnn_ex_stage_tb
  import rnn_ex_arith_pkg::*;
  import rnn_ex_wb_pkg::*;
();

  localparam int RESET_CYCLES   = 10;
  localparam int DRAIN_CYCLES   = 3;   // Two-deep pipeline plus slack
  localparam int TIMEOUT_MARGIN = 20;

  typedef struct packed {
    logic      ex_valid;
    ex_req_t   req;
    logic      load_valid;
    load_req_t load;
    logic      alu_exp;  // Result expected on the ALU port
    ex_res_t   alu_res;
    logic      ld_exp;   // Write-back expected on the load port
    wb_t       ld_wb;
  } stim_t;

  typedef struct packed {
    int      due;
    ex_res_t res;
  } alu_exp_t;

  typedef struct packed {
    int  due;
    wb_t wb;
  } load_exp_t;

  logic      clk;
  logic      rst_n;
  logic      ex_valid_i;
  ex_req_t   ex_req_i;
  logic      load_valid_i;
  load_req_t load_i;
  logic      alu_wb_valid_o;
  wb_t       alu_wb_o;
  logic      branch_taken_o;
  logic      load_wb_valid_o;
  wb_t       load_wb_o;

  stim_t     table_q[$];
  alu_exp_t  alu_q[$];
  load_exp_t load_q[$];
  word_t     wspr_model [N_WSPR] = '{default: '0};  // SPR state as seen by the model
  word_t     aspr_model [N_ASPR] = '{default: '0};
  int        value_errs   = 0;
  int        missing_errs = 0;
  int        extra_errs   = 0;

  rnn_ex_stage u_rnn_ex_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_i),
    .ex_req_i        (ex_req_i),
    .load_valid_i    (load_valid_i),
    .load_i          (load_i),
    .alu_wb_valid_o  (alu_wb_valid_o),
    .alu_wb_o        (alu_wb_o),
    .branch_taken_o  (branch_taken_o),
    .load_wb_valid_o (load_wb_valid_o),
    .load_wb_o       (load_wb_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Signed value of lane idx for lanes w bits wide
  function automatic longint lane_value(input word_t word, input int idx, input int w);
    longint v;
    v = (word >> (idx * w)) & ((64'd1 << w) - 1);
    if (v >= (longint'(1) << (w - 1)))
      v = v - (longint'(1) << w);
    return v;
  endfunction

  function automatic ex_res_t model_result(input ex_req_t r);
    ex_res_t res;
    longint  sum;
    int      lane_w;
    res.wb.rd        = r.rd;
    res.wb.data      = '0;
    res.branch_taken = 1'b0;
    case (r.op)
      OP_ADD:  res.wb.data = r.operand_a + r.operand_b;
      OP_SUB:  res.wb.data = r.operand_a - r.operand_b;
      OP_AND:  res.wb.data = r.operand_a & r.operand_b;
      OP_OR:   res.wb.data = r.operand_a | r.operand_b;
      OP_XOR:  res.wb.data = r.operand_a ^ r.operand_b;
      OP_SLT:  res.wb.data = ($signed(r.operand_a) < $signed(r.operand_b)) ? 32'd1 : 32'd0;
      OP_SLTU: res.wb.data = (r.operand_a < r.operand_b) ? 32'd1 : 32'd0;
      OP_BEQ:  res.branch_taken = (r.operand_a == r.operand_b);
      OP_BNE:  res.branch_taken = (r.operand_a != r.operand_b);
      OP_BLT:  res.branch_taken = ($signed(r.operand_a) < $signed(r.operand_b));
      OP_DOT8, OP_DOT16: begin
        lane_w = (r.op == OP_DOT8) ? XLEN / DOT8_LANES : XLEN / DOT16_LANES;
        sum    = r.operand_c;
        for (int i = 0; i < XLEN / lane_w; i++)
          sum = sum + lane_value(r.operand_a, i, lane_w) * lane_value(r.operand_b, i, lane_w);
        res.wb.data = sum[31:0];  // Modulo 2^32
      end
      default: ;
    endcase
    return res;
  endfunction

  //////////////////////////////
  // Table construction
  //////////////////////////////

  function automatic ex_req_t make_req(input ex_op_e op, input word_t a, input word_t b,
                                       input word_t c, input logic use_spr,
                                       input wspr_idx_t wsel, input aspr_idx_t asel,
                                       input logic rd_we);
    ex_req_t r;
    r.op        = op;
    r.operand_a = a;
    r.operand_b = b;
    r.operand_c = c;
    r.use_spr   = use_spr;
    r.wspr_sel  = wsel;
    r.aspr_sel  = asel;
    r.rd        = reg_addr_t'($urandom());
    r.rd_we     = rd_we;
    return r;
  endfunction

  function automatic load_req_t make_load(input load_dst_e dst, input int idx, input word_t data);
    load_req_t l;
    l.data     = data;
    l.dst      = dst;
    l.rd       = reg_addr_t'($urandom());
    l.wspr_idx = wspr_idx_t'(idx);
    l.aspr_idx = aspr_idx_t'(idx);
    return l;
  endfunction

  task automatic add_entry(input logic ex_v, input ex_req_t req, input logic ld_v,
                           input load_req_t ld);
    stim_t   e;
    ex_req_t seen;
    seen = req;
    if (req.use_spr) begin
      seen.operand_a = aspr_model[req.aspr_sel];
      seen.operand_b = wspr_model[req.wspr_sel];
    end
    e.ex_valid   = ex_v;
    e.req        = req;
    e.load_valid = ld_v;
    e.load       = ld;
    e.alu_exp    = ex_v && (req.rd_we || req.op == OP_BEQ || req.op == OP_BNE ||
                            req.op == OP_BLT);
    e.alu_res    = model_result(seen);
    e.ld_exp     = ld_v && (ld.dst == DST_GPR);
    e.ld_wb.rd   = ld.rd;
    e.ld_wb.data = ld.data;
    // SPR update becomes visible to the following entry
    if (ld_v && ld.dst == DST_WSPR)
      wspr_model[ld.wspr_idx] = ld.data;
    if (ld_v && ld.dst == DST_ASPR)
      aspr_model[ld.aspr_idx] = ld.data;
    table_q.push_back(e);
  endtask

  task automatic add_instr(input ex_op_e op, input word_t a, input word_t b, input word_t c,
                           input logic use_spr, input int wsel, input int asel);
    add_entry(1'b1, make_req(op, a, b, c, use_spr, wspr_idx_t'(wsel), aspr_idx_t'(asel),
                             1'b1), 1'b0, '0);
  endtask

  task automatic add_branch(input ex_op_e op, input word_t a, input word_t b);
    add_entry(1'b1, make_req(op, a, b, 32'h0, 1'b0, 2'd0, 1'b0, 1'b0), 1'b0, '0);
  endtask

  task automatic add_load(input load_dst_e dst, input int idx, input word_t data);
    add_entry(1'b0, '0, 1'b1, make_load(dst, idx, data));
  endtask

  task automatic build_table();
    add_instr(OP_DOT8, $urandom(), $urandom(), $urandom(), 1'b1, 3, 1);  // SPRs still zero
    add_instr(OP_DOT16, $urandom(), $urandom(), $urandom(), 1'b1, 0, 0);
    for (int n = 0; n < 21; n++)
      add_instr(ex_op_e'(n % 7), $urandom(), $urandom(), 32'h0, 1'b0, 0, 0);
    add_instr(OP_SLT, 32'h8000_0000, 32'h1, 32'h0, 1'b0, 0, 0);
    add_instr(OP_SLTU, 32'h8000_0000, 32'h1, 32'h0, 1'b0, 0, 0);
    add_entry(1'b1, make_req(OP_ADD, 32'h5, 32'h6, 32'h0, 1'b0, 2'd0, 1'b0, 1'b0),
              1'b0, '0);  // No write so no output
    add_branch(OP_BEQ, 32'h1234, 32'h1234);
    add_branch(OP_BEQ, 32'h1234, 32'h1235);
    add_branch(OP_BNE, 32'h1234, 32'h1234);
    add_branch(OP_BNE, 32'hffff_0000, 32'h0);
    add_branch(OP_BLT, 32'hffff_fffe, 32'h1);
    add_branch(OP_BLT, 32'h1, 32'h8000_0000);
    // Negative lanes and accumulator wraparound
    add_instr(OP_DOT8, 32'h80ff_7f01, 32'h7f80_ff02, 32'h10, 1'b0, 0, 0);
    add_instr(OP_DOT8, 32'h7f7f_7f7f, 32'h7f7f_7f7f, 32'h7fff_fff0, 1'b0, 0, 0);
    add_instr(OP_DOT16, 32'h8000_7fff, 32'h8000_8001, 32'h0, 1'b0, 0, 0);
    add_instr(OP_DOT16, 32'h8000_8000, 32'h8000_8000, 32'h0, 1'b0, 0, 0);
    for (int n = 0; n < 4; n++)
      add_instr(n % 2 ? OP_DOT16 : OP_DOT8, $urandom(), $urandom(), $urandom(), 1'b0, 0, 0);
    for (int k = 0; k < N_WSPR; k++)
      add_load(DST_WSPR, k, $urandom());
    for (int k = 0; k < N_ASPR; k++)
      add_load(DST_ASPR, k, $urandom());
    for (int k = 0; k < N_WSPR; k++)
      add_instr(k % 2 ? OP_DOT16 : OP_DOT8, 32'h0, 32'h0, $urandom(), 1'b1, k, k % 2);
    // Same-cycle load and use followed by a use after the load
    add_entry(1'b1, make_req(OP_DOT8, 32'h0, 32'h0, 32'h0, 1'b1, 2'd2, 1'b0, 1'b1),
              1'b1, make_load(DST_WSPR, 2, 32'h0101_0101));
    add_instr(OP_DOT8, 32'h0, 32'h0, 32'h0, 1'b1, 2, 0);
    add_entry(1'b1, make_req(OP_ADD, $urandom(), $urandom(), 32'h0, 1'b0, 2'd0, 1'b0, 1'b1),
              1'b1, make_load(DST_GPR, 0, $urandom()));
    add_load(DST_GPR, 0, $urandom());
  endtask

  //////////////////////////////
  // Drive and check
  //////////////////////////////

  task automatic apply_entry(input int k);
    stim_t     e;
    alu_exp_t  ae;
    load_exp_t le;
    e = (k < table_q.size()) ? table_q[k] : '0;
    ex_valid_i   = e.ex_valid;
    ex_req_i     = e.req;
    load_valid_i = e.load_valid;
    load_i       = e.load;
    ae.due = k + 2;
    ae.res = e.alu_res;
    le.due = k + 1;
    le.wb  = e.ld_wb;
    if (e.alu_exp)
      alu_q.push_back(ae);
    if (e.ld_exp)
      load_q.push_back(le);
  endtask

  task automatic check_outputs(input int k);
    alu_exp_t  ae;
    load_exp_t le;
    if (alu_q.size() > 0 && alu_q[0].due == k) begin
      ae = alu_q.pop_front();
      if (alu_wb_valid_o !== 1'b1) begin
        $display("ALU result due in cycle %0d did not appear (time %0t)", k, $time);
        missing_errs++;
      end else if (alu_wb_o !== ae.res.wb || branch_taken_o !== ae.res.branch_taken) begin
        $display("Error at %0t: ALU rd %0d data %h taken %b, expected rd %0d data %h taken %b",
                 $time, alu_wb_o.rd, alu_wb_o.data, branch_taken_o,
                 ae.res.wb.rd, ae.res.wb.data, ae.res.branch_taken);
        value_errs++;
      end
    end else if (alu_wb_valid_o !== 1'b0) begin
      $display("ALU port valid at %0t with no result expected", $time);
      extra_errs++;
    end
    if (load_q.size() > 0 && load_q[0].due == k) begin
      le = load_q.pop_front();
      if (load_wb_valid_o !== 1'b1) begin
        $display("Load write-back due in cycle %0d did not appear (time %0t)", k, $time);
        missing_errs++;
      end else if (load_wb_o !== le.wb) begin
        $display("Error at %0t: load port rd %0d data %h, expected rd %0d data %h",
                 $time, load_wb_o.rd, load_wb_o.data, le.wb.rd, le.wb.data);
        value_errs++;
      end
    end else if (load_wb_valid_o !== 1'b0) begin
      $display("Load port valid at %0t with no write-back expected", $time);
      extra_errs++;
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    ex_valid_i   = 1'b0;
    ex_req_i     = '0;
    load_valid_i = 1'b0;
    load_i       = '0;
    void'($urandom(32'h37fa7025));
    build_table();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      if (alu_wb_valid_o !== 1'b0 || load_wb_valid_o !== 1'b0 || branch_taken_o !== 1'b0) begin
        $display("Output valid high during reset at %0t", $time);
        extra_errs++;
      end
    end
    rst_n = 1'b1;
    for (int k = 0; k < table_q.size() + DRAIN_CYCLES; k++) begin
      @(negedge clk);
      check_outputs(k);  // Outputs settled since the last rising edge
      apply_entry(k);
    end
    $display("Errors: %0d wrong values, %0d missing results, %0d unexpected outputs",
             value_errs, missing_errs, extra_errs);
    if (value_errs + missing_errs + extra_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Cycle limit from table length and reset time
  initial begin : watchdog
    int cycle_cnt;
    int cycle_limit;
    cycle_cnt = 0;
    @(posedge clk);
    cycle_limit = table_q.size() + RESET_CYCLES + TIMEOUT_MARGIN;
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
